//--- rtl/lsq_pkg.sv
/*
 * Shared widths, types and helper functions for the load/store queue.
 * Every RTL block imports this package in its module header.
 */
package lsq_pkg;

	localparam int xlen             = 64;
	localparam int prf_tag_bits     = 6;
	localparam int rob_idx_bits     = 5;
	localparam int offset_bits      = 16;	// Displacement field of a memory instruction
	localparam int default_lq_depth = 8;
	localparam int default_sq_depth = 8;

	typedef logic [xlen-1:0]         data_t;
	typedef logic [prf_tag_bits-1:0] prf_tag_t;
	typedef logic [rob_idx_bits-1:0] rob_idx_t;
	typedef logic [offset_bits-1:0]  offset_t;

	// Value when ready, otherwise the low bits hold the producer tag
	typedef struct packed {
		logic  ready;
		data_t value;
	} operand_t;

	// One result broadcast
	typedef struct packed {
		logic     valid;
		prf_tag_t tag;
		data_t    data;
	} cdb_t;

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Snoop the CDB for a pending operand
	function automatic operand_t capture(operand_t op, cdb_t bus);
		operand_t res;
		res = op;
		if (!op.ready && bus.valid && bus.tag == op.value[prf_tag_bits-1:0]) begin
			res.ready = 1'b1;
			res.value = bus.data;
		end
		return res;
	endfunction

	// Base plus sign-extended displacement
	function automatic data_t eff_addr(data_t base, offset_t offset);
		return base + {{(xlen-offset_bits){offset[offset_bits-1]}}, offset};
	endfunction

endpackage

//--- rtl/mem_req_if.sv
/*
 * Request channel from one queue to the memory port.
 * The requester holds req and its fields until done. Grant marks
 * acceptance, and done ends the bus cycle with rdata valid.
 */
`timescale 1ns/1ps

interface mem_req_if import lsq_pkg::*; ();

	logic  req;		// Held until done
	data_t addr;
	logic  write;		// High for a store
	data_t wdata;

	logic  grant;		// One pulse when the arbiter takes the request
	logic  done;		// One pulse when the bus cycle ends
	data_t rdata;		// Valid with done

	modport requester (
		output req, addr, write, wdata,
		input  grant, done, rdata
	);

	modport arbiter (
		input  req, addr, write, wdata,
		output grant, done, rdata
	);

endinterface

//--- rtl/load_queue.sv
/*
 * Load entries waiting for their base and for older stores to drain.
 * The lowest ready entry goes to the memory port, and the returned
 * data is broadcast on the result channel one cycle after done.
 */
`timescale 1ns/1ps

module load_queue import lsq_pkg::*; #(
	parameter int LQ_DEPTH = default_lq_depth,
	parameter int SQ_DEPTH = default_sq_depth
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          flush,
	input  logic                          enq,
	input  operand_t                      enq_base,
	input  offset_t                       enq_offset,
	input  prf_tag_t                      enq_dest_tag,
	input  rob_idx_t                      enq_rob_idx,
	input  logic [$clog2(SQ_DEPTH+1)-1:0] older_stores,	// Store queue occupancy
	input  cdb_t                          cdb,
	input  logic                          store_done,
	mem_req_if.requester                  mem,
	output cdb_t                          result,
	output rob_idx_t                      result_rob_idx,
	output logic                          almost_full
);
	localparam int idx_bits = (LQ_DEPTH > 1) ? $clog2(LQ_DEPTH) : 1;
	localparam int cnt_bits = $clog2(SQ_DEPTH+1);

	logic [LQ_DEPTH-1:0] valid;
	operand_t            base     [LQ_DEPTH];
	offset_t             offset   [LQ_DEPTH];
	prf_tag_t            dest_tag [LQ_DEPTH];
	rob_idx_t            rob_idx  [LQ_DEPTH];
	logic [cnt_bits-1:0] wait_cnt [LQ_DEPTH];	// Older stores still to write

	logic                      busy;		// A request is held
	logic                      granted;	// Held request is on the bus
	logic                      live;		// Held load survived any flush
	logic [idx_bits-1:0]       busy_idx;
	logic [idx_bits-1:0]       sel_idx;
	logic [idx_bits-1:0]       free_idx;
	logic [idx_bits-1:0]       req_idx;
	logic                      sel_found;
	logic [$clog2(LQ_DEPTH+1)-1:0] used;
	logic [cnt_bits-1:0]       enq_cnt;
	logic                      res_valid;
	prf_tag_t                  res_tag;
	data_t                     res_data;

	// Scan from the top so the lowest index wins
	always_comb begin
		sel_found = 1'b0;
		sel_idx   = '0;
		free_idx  = '0;
		used      = '0;
		for (int i = LQ_DEPTH-1; i >= 0; i--) begin
			if (valid[i] && base[i].ready && wait_cnt[i] == '0) begin
				sel_found = 1'b1;
				sel_idx   = idx_bits'(i);
			end
			if (!valid[i])
				free_idx = idx_bits'(i);
			used = used + valid[i];
		end
	end

	// A store finishing this cycle is not older for the new load
	assign enq_cnt = (store_done && older_stores != '0) ? older_stores - 1'b1 : older_stores;
	assign almost_full = used >= LQ_DEPTH - 1;

	assign req_idx   = busy ? busy_idx : sel_idx;
	assign mem.req   = busy | sel_found;
	assign mem.addr  = eff_addr(base[req_idx].value, offset[req_idx]);
	assign mem.write = 1'b0;
	assign mem.wdata = '0;

	assign result         = '{valid: res_valid, tag: res_tag, data: res_data};

	//////////////////////////////
	// Entry and request control
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			valid     <= '0;
			busy      <= 1'b0;
			granted   <= 1'b0;
			live      <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			res_valid <= 1'b0;
			if (enq)
				valid[free_idx] <= 1'b1;
			if (!busy && sel_found) begin	// Lock the choice until done
				busy     <= 1'b1;
				busy_idx <= sel_idx;
				live     <= 1'b1;
			end
			if (mem.grant)
				granted <= 1'b1;
			if (mem.done) begin
				busy    <= 1'b0;
				granted <= 1'b0;
			end
			if (mem.done && live) begin
				valid[busy_idx] <= 1'b0;	// Entry frees as the result goes out
				res_valid       <= 1'b1;
			end
			if (flush) begin
				valid     <= '0;
				live      <= 1'b0;
				res_valid <= 1'b0;
				if (!granted && !mem.grant)
					busy <= 1'b0;	// Never reached the bus, just drop it
			end
		end
	end

	always_ff @(posedge clock) begin
		if (mem.done) begin
			res_tag        <= dest_tag[busy_idx];
			res_data       <= mem.rdata;
			result_rob_idx <= rob_idx[busy_idx];
		end
		for (int i = 0; i < LQ_DEPTH; i++) begin
			if (enq && free_idx == idx_bits'(i)) begin
				base[i]     <= capture(enq_base, cdb);
				offset[i]   <= enq_offset;
				dest_tag[i] <= enq_dest_tag;
				rob_idx[i]  <= enq_rob_idx;
				wait_cnt[i] <= enq_cnt;
			end else begin
				base[i] <= capture(base[i], cdb);
				if (store_done && wait_cnt[i] != '0)
					wait_cnt[i] <= wait_cnt[i] - 1'b1;
			end
		end
	end

endmodule

//--- rtl/store_queue.sv
/*
 * Circular store buffer. Stores wait for operands and for commit,
 * then write memory in program order from the head.
 * Occupancy and store_done keep the load queue ordered behind them.
 */
`timescale 1ns/1ps

module store_queue import lsq_pkg::*; #(
	parameter int SQ_DEPTH = default_sq_depth
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          flush,
	input  logic                          enq,
	input  operand_t                      enq_base,
	input  operand_t                      enq_data,
	input  offset_t                       enq_offset,
	input  rob_idx_t                      enq_rob_idx,
	input  cdb_t                          cdb,
	input  logic                          commit_valid,
	input  rob_idx_t                      commit_rob_idx,
	mem_req_if.requester                  mem,
	output logic                          store_done,
	output logic [$clog2(SQ_DEPTH+1)-1:0] occupancy,
	output logic                          almost_full
);
	localparam int ptr_bits = (SQ_DEPTH > 1) ? $clog2(SQ_DEPTH) : 1;

	logic [SQ_DEPTH-1:0] valid;
	logic [SQ_DEPTH-1:0] committed;
	operand_t            base    [SQ_DEPTH];
	operand_t            data    [SQ_DEPTH];
	offset_t             offset  [SQ_DEPTH];
	rob_idx_t            rob_idx [SQ_DEPTH];

	logic [ptr_bits-1:0] head;
	logic [ptr_bits-1:0] tail;
	logic                live;		// Bus cycle in flight belongs to the head

	function automatic logic [ptr_bits-1:0] next_ptr(logic [ptr_bits-1:0] p);
		return (p == ptr_bits'(SQ_DEPTH-1)) ? '0 : p + 1'b1;
	endfunction

	// Head writes once committed and both operands are in
	assign mem.req   = occupancy != '0 && committed[head] && base[head].ready && data[head].ready;
	assign mem.addr  = eff_addr(base[head].value, offset[head]);
	assign mem.write = 1'b1;
	assign mem.wdata = data[head].value;

	assign store_done  = mem.done & live;	// A flushed store writes but is not counted
	assign almost_full = occupancy >= SQ_DEPTH - 1;

	//////////////////////////////
	// Pointers and status
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			head      <= '0;
			tail      <= '0;
			occupancy <= '0;
			valid     <= '0;
			committed <= '0;
			live      <= 1'b0;
		end else begin
			if (mem.grant)
				live <= 1'b1;
			if (mem.done)
				live <= 1'b0;
			if (enq) begin
				valid[tail]     <= 1'b1;
				committed[tail] <= 1'b0;
				tail            <= next_ptr(tail);
			end
			if (store_done) begin
				valid[head] <= 1'b0;
				head        <= next_ptr(head);
			end
			if (enq && !store_done)
				occupancy <= occupancy + 1'b1;
			else if (!enq && store_done)
				occupancy <= occupancy - 1'b1;
			for (int i = 0; i < SQ_DEPTH; i++) begin
				if (commit_valid && valid[i] && rob_idx[i] == commit_rob_idx)
					committed[i] <= 1'b1;	// Safe to make visible
			end
			if (flush) begin
				head      <= '0;
				tail      <= '0;
				occupancy <= '0;
				valid     <= '0;
				committed <= '0;
				live      <= 1'b0;
			end
		end
	end

	// Entry payload and operand capture
	always_ff @(posedge clock) begin
		for (int i = 0; i < SQ_DEPTH; i++) begin
			if (enq && tail == ptr_bits'(i)) begin
				base[i]    <= capture(enq_base, cdb);
				data[i]    <= capture(enq_data, cdb);
				offset[i]  <= enq_offset;
				rob_idx[i] <= enq_rob_idx;
			end else begin
				base[i] <= capture(base[i], cdb);
				data[i] <= capture(data[i], cdb);
			end
		end
	end

endmodule

//--- rtl/mem_port.sv
/*
 * Memory port. Picks one queue request, store queue first, and runs
 * it as a Wishbone classic cycle. Ack comes back as done to the owner
 * with the read data passed straight through.
 */
`timescale 1ns/1ps

module mem_port import lsq_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	mem_req_if.arbiter  lq,
	mem_req_if.arbiter  sq,
	output logic        wb_cyc,
	output logic        wb_stb,
	output logic        wb_we,
	output data_t       wb_adr,
	output data_t       wb_dat_w,
	input  data_t       wb_dat_r,
	input  logic        wb_ack
);
	typedef enum logic {
		st_idle,
		st_busy
	} state_t;

	state_t state;
	logic   owner_sq;	// Bus cycle belongs to the store queue

	assign sq.grant = state == st_idle && sq.req;
	assign lq.grant = state == st_idle && lq.req && !sq.req;

	assign sq.done  = state == st_busy && owner_sq && wb_ack;
	assign lq.done  = state == st_busy && !owner_sq && wb_ack;
	assign sq.rdata = wb_dat_r;
	assign lq.rdata = wb_dat_r;	// Load queue registers it with done

	assign wb_cyc = state == st_busy;
	assign wb_stb = state == st_busy;	// Classic cycle, stb follows cyc

	//////////////////////////////
	// Bus state
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: if (sq.req || lq.req)
					state <= st_busy;
				st_busy: if (wb_ack)
					state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	// Latch the granted request for the whole cycle
	always_ff @(posedge clock) begin
		if (state == st_idle) begin
			owner_sq <= sq.req;
			wb_we    <= sq.req ? sq.write : lq.write;
			wb_adr   <= sq.req ? sq.addr  : lq.addr;
			wb_dat_w <= sq.req ? sq.wdata : lq.wdata;
		end
	end

endmodule

//--- rtl/lsq_top.sv
/*
 * Load/store queue top level. Steers dispatch to the load or store
 * queue, raises lsq_full and exposes dispatch, CDB, commit, result
 * and the Wishbone master as plain ports.
 */
`timescale 1ns/1ps

module lsq_top import lsq_pkg::*; #(
	parameter int LQ_DEPTH = default_lq_depth,
	parameter int SQ_DEPTH = default_sq_depth
) (
	input  logic        clock,
	input  logic        reset,
	// Dispatch
	input  logic        dispatch_valid,
	input  logic        dispatch_store,
	input  rob_idx_t    dispatch_rob_idx,
	input  prf_tag_t    dispatch_dest_tag,
	input  logic [xlen:0] dispatch_base,	// Ready flag on top, then value or tag
	input  offset_t     dispatch_offset,
	input  logic [xlen:0] dispatch_data,	// Same layout, stores only
	// Result bus in, commit and flush
	input  logic        cdb_valid,
	input  prf_tag_t    cdb_tag,
	input  data_t       cdb_data,
	input  logic        commit_valid,
	input  rob_idx_t    commit_rob_idx,
	input  logic        flush,
	// Load results
	output logic        result_valid,
	output prf_tag_t    result_tag,
	output data_t       result_data,
	output rob_idx_t    result_rob_idx,
	// Wishbone classic master
	output logic        wb_cyc,
	output logic        wb_stb,
	output logic        wb_we,
	output data_t       wb_adr,
	output data_t       wb_dat_w,
	input  data_t       wb_dat_r,
	input  logic        wb_ack,
	output logic        lsq_full
);
	mem_req_if lq_mem ();
	mem_req_if sq_mem ();

	operand_t disp_base;
	operand_t disp_data;
	cdb_t     cdb;
	cdb_t     result;
	logic     lq_enq;
	logic     sq_enq;
	logic     lq_almost_full;
	logic     sq_almost_full;
	logic     store_done;
	logic [$clog2(SQ_DEPTH+1)-1:0] sq_occupancy;

	assign disp_base = dispatch_base;
	assign disp_data = dispatch_data;
	assign cdb       = '{valid: cdb_valid, tag: cdb_tag, data: cdb_data};

	assign lq_enq   = dispatch_valid && !lsq_full && !dispatch_store;
	assign sq_enq   = dispatch_valid && !lsq_full && dispatch_store;
	assign lsq_full = lq_almost_full | sq_almost_full;	// One slot kept in each queue

	assign result_valid = result.valid;
	assign result_tag   = result.tag;
	assign result_data  = result.data;

	load_queue #(.LQ_DEPTH(LQ_DEPTH), .SQ_DEPTH(SQ_DEPTH)) u_load_queue (
		.clock(clock), .reset(reset), .flush(flush),
		.enq(lq_enq), .enq_base(disp_base), .enq_offset(dispatch_offset),
		.enq_dest_tag(dispatch_dest_tag), .enq_rob_idx(dispatch_rob_idx),
		.older_stores(sq_occupancy), .cdb(cdb), .store_done(store_done),
		.mem(lq_mem.requester), .result(result), .result_rob_idx(result_rob_idx),
		.almost_full(lq_almost_full)
	);

	store_queue #(.SQ_DEPTH(SQ_DEPTH)) u_store_queue (
		.clock(clock), .reset(reset), .flush(flush),
		.enq(sq_enq), .enq_base(disp_base), .enq_data(disp_data),
		.enq_offset(dispatch_offset), .enq_rob_idx(dispatch_rob_idx), .cdb(cdb),
		.commit_valid(commit_valid), .commit_rob_idx(commit_rob_idx),
		.mem(sq_mem.requester), .store_done(store_done),
		.occupancy(sq_occupancy), .almost_full(sq_almost_full)
	);

	mem_port u_mem_port (
		.clock(clock), .reset(reset), .lq(lq_mem.arbiter), .sq(sq_mem.arbiter),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
	);

endmodule

//--- sim/tb_mem_model.sv
/*
 * Wishbone classic slave memory for the testbench. Each cycle is acked
 * after 0 to 3 wait states drawn from an LFSR, and writes are logged.
 */
`timescale 1ns/1ps

module tb_mem_model import lsq_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  logic  wb_cyc,
	input  logic  wb_stb,
	input  logic  wb_we,
	input  data_t wb_adr,
	input  data_t wb_dat_w,
	output data_t wb_dat_r,
	output logic  wb_ack
);
	data_t       mem [data_t];
	data_t       log_adr [$];	// Write addresses in bus order
	logic [31:0] lfsr;
	logic        armed;		// Wait states already drawn for this cycle
	int          wait_left;

	// Galois LFSR for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// Power-on contents mix every address bit
	function automatic data_t fill(data_t a);
		return (a * 64'h9e37_79b9_7f4a_7c15) ^ {a[31:0], a[63:32]};
	endfunction

	// Perform the access and raise ack for one cycle
	task automatic finish_cycle();
		wb_ack <= 1'b1;
		if (wb_we) begin
			mem[wb_adr] = wb_dat_w;
			log_adr.push_back(wb_adr);
		end else begin
			wb_dat_r <= mem.exists(wb_adr) ? mem[wb_adr] : fill(wb_adr);
		end
	endtask

	initial begin
		wb_ack   = 1'b0;
		wb_dat_r = '0;
	end

	always @(posedge clock) begin : slave
		logic [31:0] s;
		logic [1:0]  delay;
		if (reset) begin
			wb_ack <= 1'b0;
			armed  <= 1'b0;
			lfsr   <= 32'h660c_7a4d;
		end else if (wb_ack) begin
			wb_ack <= 1'b0;	// Master drops cyc on this edge
			armed  <= 1'b0;
		end else if (wb_cyc && wb_stb && !armed) begin
			s     = lfsr_step(lfsr);
			delay = {s[0], lfsr[0]};	// One step per bit
			lfsr  <= lfsr_step(s);
			if (delay == 2'd0) begin
				finish_cycle();
			end else begin
				armed     <= 1'b1;
				wait_left <= int'(delay) - 1;
			end
		end else if (armed) begin
			if (wait_left == 0)
				finish_cycle();
			else
				wait_left <= wait_left - 1;
		end
	end

endmodule

//--- sim/tb_lsq.sv
/*
 * Testbench for the load/store queue. Drives dispatch, CDB, commit and
 * flush, keeps a reference memory and expected results, and checks the
 * DUT with concurrent assertions. A watchdog bounds the run.
 */
`timescale 1ns/1ps

module tb_lsq import lsq_pkg::*; ();

	localparam int lq_depth = default_lq_depth;
	localparam int sq_depth = default_sq_depth;
	// Operations per test, with the flush test's quiet window
	localparam int watchdog_cycles = (6 + 8 + 6 + 9 + 30) * 64;

	logic            clock, reset, flush;
	logic            dispatch_valid, dispatch_store;
	rob_idx_t        dispatch_rob_idx, commit_rob_idx, result_rob_idx;
	prf_tag_t        dispatch_dest_tag, cdb_tag, result_tag;
	logic [xlen:0]   dispatch_base, dispatch_data;
	offset_t         dispatch_offset;
	logic            cdb_valid, commit_valid, result_valid, lsq_full;
	data_t           cdb_data, result_data;
	logic            wb_cyc, wb_stb, wb_we, wb_ack;
	data_t           wb_adr, wb_dat_w, wb_dat_r;

	data_t    ref_mem [data_t];
	prf_tag_t exp_tag [32];
	data_t    exp_data [32];
	int       issued [32];
	int       done_cnt [32];
	data_t    st_adr [64];
	data_t    st_dat [64];
	rob_idx_t st_rob [64];
	int       st_total, st_committed, st_written;
	int       exp_loads, seen_results, lq_cnt, sq_cnt;
	int       errors, err_mark, tests;
	rob_idx_t rob_next;
	prf_tag_t dest_next;
	rob_idx_t flushed_rob;	// ROB index of the store that the flush removes
	logic     speculative;	// Instructions that a flush will remove
	logic     quiet;
	data_t    exp_wr_adr, exp_wr_dat;
	logic     full_exp;

	assign exp_wr_adr = st_adr[st_written];
	assign exp_wr_dat = st_dat[st_written];
	assign full_exp   = lq_cnt >= lq_depth - 1 || sq_cnt >= sq_depth - 1;

	lsq_top dut0 (.*);
	tb_mem_model mem0 (.*);

	always #10 clock = ~clock;

	function automatic data_t fill(data_t a);
		return (a * 64'h9e37_79b9_7f4a_7c15) ^ {a[31:0], a[63:32]};
	endfunction

	function automatic data_t target(data_t base, offset_t off);
		return base + data_t'(longint'($signed(off)));
	endfunction

	// Ready value, or a pending tag when t is not negative
	function automatic logic [xlen:0] operand(data_t v, int t);
		if (t < 0)
			return {1'b1, v};
		return {1'b0, data_t'(t)};
	endfunction

	task automatic note_error(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	task automatic step();
		@(posedge clock);
		#2;
	endtask

	task automatic dispatch(input logic st, input logic [xlen:0] base, input offset_t off,
			input logic [xlen:0] data);
		while (lsq_full)
			step();
		dispatch_valid    = 1'b1;
		dispatch_store    = st;
		dispatch_rob_idx  = rob_next;
		dispatch_dest_tag = dest_next;
		dispatch_base     = base;
		dispatch_offset   = off;
		dispatch_data     = data;
		step();
		dispatch_valid = 1'b0;
		rob_next++;
		dest_next++;
	endtask

	task automatic do_load(input data_t base, input offset_t off, input int base_tag);
		data_t addr;
		addr = target(base, off);
		if (!speculative) begin
			exp_tag[rob_next]  = dest_next;
			exp_data[rob_next] = ref_mem.exists(addr) ? ref_mem[addr] : fill(addr);
			issued[rob_next]++;
			exp_loads++;
		end
		dispatch(1'b0, operand(base, base_tag), off, '0);
	endtask

	task automatic do_store(input data_t base, input offset_t off, input int base_tag,
			input data_t data, input int data_tag);
		data_t addr;
		addr = target(base, off);
		if (!speculative) begin
			ref_mem[addr]    = data;	// Program order
			st_adr[st_total] = addr;
			st_dat[st_total] = data;
			st_rob[st_total] = rob_next;
			st_total++;
		end
		dispatch(1'b1, operand(base, base_tag), off, operand(data, data_tag));
	endtask

	task automatic broadcast(input prf_tag_t t, input data_t d);
		cdb_valid = 1'b1;
		cdb_tag   = t;
		cdb_data  = d;
		step();
		cdb_valid = 1'b0;
	endtask

	task automatic commit_store();
		commit_valid   = 1'b1;
		commit_rob_idx = st_rob[st_committed];
		st_committed++;
		step();
		commit_valid = 1'b0;
	endtask

	task automatic wait_loads();
		while (seen_results < exp_loads)
			step();
	endtask

	task automatic drain();
		wait_loads();
		while (st_written < st_total)
			step();
	endtask

	task automatic report(input string name);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - err_mark);
		err_mark = errors;
	endtask

	//////////////////////////////
	// Bookkeeping
	//////////////////////////////
	always @(posedge clock) begin
		if (reset || flush) begin
			lq_cnt <= 0;
			sq_cnt <= 0;
		end else begin
			lq_cnt <= lq_cnt + int'(dispatch_valid && !lsq_full && !dispatch_store)
				- int'(wb_cyc && wb_ack && !wb_we);
			sq_cnt <= sq_cnt + int'(dispatch_valid && !lsq_full && dispatch_store)
				- int'(wb_cyc && wb_ack && wb_we);
		end
		if (!reset && result_valid) begin
			done_cnt[result_rob_idx] <= done_cnt[result_rob_idx] + 1;
			seen_results <= seen_results + 1;
		end
		if (!reset && wb_cyc && wb_ack && wb_we)
			st_written <= st_written + 1;
	end

	//////////////////////////////
	// Checks
	//////////////////////////////
	a_cyc_stb: assert property (@(posedge clock) disable iff (reset) wb_cyc == wb_stb)
		else note_error($sformatf("FAILED wb_stb got %h exp %h",
			$sampled(wb_stb), $sampled(wb_cyc)));
	a_hold: assert property (@(posedge clock) disable iff (reset) wb_cyc && !wb_ack |=>
			wb_cyc && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w))
		else note_error("bus cycle dropped or changed before its ack");
	a_res_lat: assert property (@(posedge clock) disable iff (reset)
			wb_cyc && wb_ack && !wb_we |=> result_valid)
		else note_error("no result one cycle after a load ack");
	a_res_src: assert property (@(posedge clock) disable iff (reset)
			result_valid |-> $past(wb_cyc && wb_ack && !wb_we))
		else note_error("result without a load ack in the cycle before");
	a_res_known: assert property (@(posedge clock) disable iff (reset)
			result_valid |-> issued[result_rob_idx] > done_cnt[result_rob_idx])
		else note_error($sformatf("result for rob %0d with no load outstanding", result_rob_idx));
	a_res_tag: assert property (@(posedge clock) disable iff (reset)
			result_valid |-> result_tag == exp_tag[result_rob_idx])
		else note_error($sformatf("FAILED result_tag got %h exp %h",
			result_tag, exp_tag[result_rob_idx]));
	a_res_data: assert property (@(posedge clock) disable iff (reset)
			result_valid |-> result_data == exp_data[result_rob_idx])
		else note_error($sformatf("FAILED result_data got %h exp %h",
			result_data, exp_data[result_rob_idx]));
	a_st_commit: assert property (@(posedge clock) disable iff (reset)
			wb_cyc && wb_we |-> st_written < st_committed)
		else note_error("store on the bus before its commit");
	a_st_adr: assert property (@(posedge clock) disable iff (reset)
			wb_cyc && wb_we |-> wb_adr == exp_wr_adr)
		else note_error($sformatf("FAILED wb_adr got %h exp %h",
			wb_adr, $sampled(exp_wr_adr)));
	a_st_dat: assert property (@(posedge clock) disable iff (reset)
			wb_cyc && wb_we |-> wb_dat_w == exp_wr_dat)
		else note_error($sformatf("FAILED wb_dat_w got %h exp %h",
			wb_dat_w, $sampled(exp_wr_dat)));
	a_full: assert property (@(posedge clock) disable iff (reset) lsq_full == full_exp)
		else note_error($sformatf("FAILED lsq_full got %h exp %h",
			$sampled(lsq_full), $sampled(full_exp)));
	a_quiet: assert property (@(posedge clock) disable iff (reset)
			quiet |-> !wb_cyc && !result_valid)
		else note_error("bus cycle or result for a flushed instruction");

	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("timeout after %0d cycles, tests did not finish", watchdog_cycles);
		$display("sim failed");
		$finish;
	end

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		flush = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_store = 1'b0;
		dispatch_rob_idx = '0;
		dispatch_dest_tag = '0;
		dispatch_base = '0;
		dispatch_offset = '0;
		dispatch_data = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		commit_valid = 1'b0;
		commit_rob_idx = '0;
		rob_next = '0;
		dest_next = '0;
		flushed_rob = '0;
		speculative = 1'b0;
		quiet = 1'b0;
		repeat (2) @(posedge clock);
		#2 reset = 1'b0;

		// Ready operands, including negative offsets and a wrap past zero
		do_load(64'h1000, 16'h0008, -1);
		do_load(64'h1000, 16'hfff8, -1);
		do_load(64'h2000_0000_0040, 16'h7ff0, -1);
		do_load(64'hffff_ffff_ffff_fff0, 16'h0010, -1);
		do_load(64'h0123_4567_89ab_cdef, 16'h8000, -1);
		do_load(64'h1000, 16'h0008, -1);
		drain();
		report("ready loads");

		do_load(64'h3000, 16'h0010, 5);
		do_store(64'h4000, 16'hfffc, 6, 64'hdead_beef_0123_4567, 7);
		broadcast(7, 64'hdead_beef_0123_4567);
		broadcast(5, 64'h3000);
		broadcast(6, 64'h4000);
		wait_loads();
		commit_store();
		cdb_valid = 1'b1;	// Broadcast in the dispatch cycle
		cdb_tag   = 8;
		cdb_data  = 64'h5000;
		do_load(64'h5000, 16'h0020, 8);
		cdb_valid = 1'b0;
		do_load(64'h4000, 16'hfffc, -1);
		drain();
		report("tag operands");

		do_store(64'h6000, 16'h0000, -1, 64'h1111_2222_3333_4444, -1);
		do_store(64'h6000, 16'h0008, -1, 64'h5555_6666_7777_8888, -1);
		do_load(64'h6000, 16'h0000, -1);
		do_load(64'h6008, 16'h0000, -1);
		repeat (4) step();	// Loads stay behind uncommitted stores
		commit_store();
		commit_store();
		drain();
		report("store then load");

		for (int i = 0; i < 6; i++)
			do_load(64'h7000 + 24 * i, offset_t'(8 * i), -1);
		do_store(64'h7000, 16'h0000, -1, 64'h0f0f_a5a5_3c3c_9696, -1);
		wait_loads();
		commit_store();
		do_load(64'h7000, 16'h0000, -1);
		drain();
		report("wait states");

		speculative = 1'b1;
		flushed_rob = rob_next;
		do_store(64'h8000, 16'h0000, -1, 64'hbad0_bad0_bad0_bad0, -1);
		for (int i = 0; i < lq_depth - 1; i++)
			do_load(64'h8000, offset_t'(8 * i), -1);
		step();
		flush = 1'b1;
		step();
		flush       = 1'b0;
		speculative = 1'b0;
		quiet       = 1'b1;
		commit_valid   = 1'b1;	// Reused ROB index finds no store left to drain
		commit_rob_idx = flushed_rob;
		step();
		commit_valid = 1'b0;
		repeat (19) step();
		quiet = 1'b0;
		do_load(64'h8000, 16'h0000, -1);
		drain();
		report("flush");

		repeat (4) step();
		a_wr_log: assert (mem0.log_adr.size() == st_total)
			else note_error($sformatf("memory saw %0d writes where %0d stores were committed",
				mem0.log_adr.size(), st_total));
		$display("tests %0d, results %0d, stores %0d, errors %0d",
			tests, seen_results, st_written, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- lsq.f
rtl/lsq_pkg.sv
rtl/mem_req_if.sv
rtl/load_queue.sv
rtl/store_queue.sv
rtl/mem_port.sv
rtl/lsq_top.sv
sim/tb_mem_model.sv
sim/tb_lsq.sv

//--- run_sim.sh
#!/bin/sh
# Build the load/store queue testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_lsq -f lsq.f \
	&& ./obj_dir/Vtb_lsq | tee /dev/stderr | grep -qx "sim passed" \
	|| { echo "simulation run did not pass" >&2; exit 1; }
